// ==== include/cache_tb_defs.svh ====
/* Cache testbench constants, DUT sizing, run length and seed */
`ifndef CACHE_TB_DEFS_SVH
`define CACHE_TB_DEFS_SVH

// DUT parameters
`define CACHE_TB_ENTRIES      16
`define CACHE_TB_BLOCK_WORDS  4

// Clock period in ns, reset length in cycles
`define CACHE_TB_CLK_PERIOD   100
`define CACHE_TB_RST_CYCLES   3

// Random phase
`define CACHE_TB_NUM_REQS     2000  // Requests in the random mix
`define CACHE_TB_TAG_POOL     4     // Distinct tags, forces aliasing
`define CACHE_TB_SEED         66

// Response latency in cycles
`define CACHE_TB_LATENCY      2

`endif

// ==== dv/cache_tb.sv ====
/* Testbench for the SI read cache, directed and random requests
   checked against a model of the directory and data array */
`timescale 1ns/100ps
`include "cache_tb_defs.svh"

module cache_tb import cache_pkg::*;;

  localparam int ENTRIES       = `CACHE_TB_ENTRIES;
  localparam int BLOCK_WORDS   = `CACHE_TB_BLOCK_WORDS;
  localparam int CLK_PERIOD    = `CACHE_TB_CLK_PERIOD;
  localparam int LATENCY       = `CACHE_TB_LATENCY;
  localparam int DIRECTED_REQS = 40;  // Directed cycles incl. reset and idles, upper bound
  localparam int TOTAL_REQS    = `CACHE_TB_NUM_REQS + DIRECTED_REQS;
  localparam int BYTE_OFF_W    = $clog2(BE_WIDTH);
  localparam int IDX_LSB       = BYTE_OFF_W + $clog2(BLOCK_WORDS);
  localparam int TAG_LSB       = IDX_LSB + $clog2(ENTRIES);

  typedef struct packed {
    logic                  hit;
    logic [WORD_WIDTH-1:0] data;
    logic [WORD_WIDTH-1:0] mask;  // Known bytes on a hit
  } expect_t;

  logic       clk;
  logic       rst_n;
  logic       req_valid;
  cache_req_t req;
  logic       rsp_valid;
  cache_rsp_t rsp;
  logic       read_req;  // Read strobe at the DUT input
  int         seed;

  // Model of directory and data array, updated in request order
  logic                  m_valid [ENTRIES];
  logic [ADDR_WIDTH-1:0] m_tag   [ENTRIES];
  logic [WORD_WIDTH-1:0] m_data  [ENTRIES][BLOCK_WORDS];
  logic [WORD_WIDTH-1:0] m_known [ENTRIES][BLOCK_WORDS];  // Unreset data starts unknown
  expect_t               exp_q[$];

  cache_top #(
    .ENTRIES     (ENTRIES),
    .BLOCK_WORDS (BLOCK_WORDS)
  ) dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp       (rsp)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  assign read_req = req_valid && (req.op == OP_READ);

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Simulation failed");
    $fatal(1);
  endtask

  // Tag, line and word fields of a byte address
  function automatic logic [ADDR_WIDTH-1:0] make_addr(input int tag, input int ln, input int wd);
    return (ADDR_WIDTH'(tag) << TAG_LSB) | (ADDR_WIDTH'(ln) << IDX_LSB) |
           (ADDR_WIDTH'(wd) << BYTE_OFF_W);
  endfunction

  // Drive one request and apply it to the model
  task automatic send(input cache_op_e op, input logic [ADDR_WIDTH-1:0] addr,
                      input logic [WORD_WIDTH-1:0] wdata, input logic [BE_WIDTH-1:0] be);
    int                    ln;
    int                    wd;
    logic [ADDR_WIDTH-1:0] tg;
    expect_t               e;
    ln = int'((addr >> IDX_LSB) % ENTRIES);
    wd = int'((addr >> BYTE_OFF_W) % BLOCK_WORDS);
    tg = addr >> TAG_LSB;
    @(posedge clk);
    req_valid <= 1'b1;
    req.op    <= op;
    req.addr  <= addr;
    req.wdata <= wdata;
    req.be    <= be;
    case (op)
      OP_READ: begin
        e.hit  = m_valid[ln] && (m_tag[ln] == tg);
        e.data = m_data[ln][wd];
        e.mask = e.hit ? m_known[ln][wd] : '0;  // Miss data is meaningless
        exp_q.push_back(e);
      end
      OP_WRITE: begin
        if (|be) begin  // Zero enables allocate nothing
          for (int b = 0; b < BE_WIDTH; b++) begin
            if (be[b]) begin
              m_data[ln][wd][b*8 +: 8]  = wdata[b*8 +: 8];
              m_known[ln][wd][b*8 +: 8] = 8'hFF;
            end
          end
          m_valid[ln] = 1'b1;
          m_tag[ln]   = tg;
        end
      end
      OP_INVAL: begin
        if (m_valid[ln] && (m_tag[ln] == tg)) m_valid[ln] = 1'b0;
      end
      default: ;  // Unused opcode is dropped
    endcase
  endtask

  task automatic idle();
    @(posedge clk);
    req_valid <= 1'b0;
  endtask

  // Strobe timing, response registers LATENCY edges after the request edge
  assert property (@(posedge clk) disable iff (!rst_n) rsp_valid == $past(read_req, LATENCY + 1))
    else abort_run($sformatf("mismatch at %0d ns: rsp_valid %0b not a delayed read strobe",
                             $time, rsp_valid));

  // Payload against the model, sampled away from the driving edge
  always @(negedge clk) begin
    expect_t e;
    if (rst_n && rsp_valid) begin
      assert (exp_q.size() > 0)
        else abort_run($sformatf("mismatch at %0d ns: response with no read pending", $time));
      e = exp_q.pop_front();
      assert (rsp.hit == e.hit)
        else abort_run($sformatf("mismatch at %0d ns: hit %0b expected %0b",
                                 $time, rsp.hit, e.hit));
      assert (((rsp.data ^ e.data) & e.mask) == '0)
        else abort_run($sformatf("mismatch at %0d ns: data %h expected %h mask %h",
                                 $time, rsp.data, e.data, e.mask));
    end
  end

  // Watchdog
  initial begin
    #((TOTAL_REQS + 20) * CLK_PERIOD);
    abort_run("Timeout: the run did not finish in time");
  end

  initial begin
    int                    kind;
    logic [WORD_WIDTH-1:0] wdata;
    logic [BE_WIDTH-1:0]   be;
    logic [ADDR_WIDTH-1:0] addr;
    seed      = `CACHE_TB_SEED;
    clk       = 1'b0;
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    for (int i = 0; i < ENTRIES; i++) begin
      m_valid[i] = 1'b0;
      m_tag[i]   = '0;
      for (int w = 0; w < BLOCK_WORDS; w++) begin
        m_data[i][w]  = '0;
        m_known[i][w] = '0;
      end
    end
    repeat (`CACHE_TB_RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    // Cold cache, back to back reads all miss
    for (int i = 0; i < 8; i++) begin
      send(OP_READ, make_addr(i % 4, (i * 3) % ENTRIES, i % BLOCK_WORDS), '0, '0);
    end
    idle();
    // Write allocate, hit, other word of the line, alias
    send(OP_WRITE, make_addr(1, 3, 2), 32'hBEEF_0002, 4'hF);
    send(OP_WRITE, make_addr(0, 3, 1), 32'hCAFE_0001, 4'hF);  // Retags line 3
    send(OP_READ, make_addr(0, 3, 1), '0, '0);
    send(OP_READ, make_addr(0, 3, 2), '0, '0);  // Word left by tag 1
    send(OP_READ, make_addr(1, 3, 1), '0, '0);  // Alias miss
    send(OP_READ, make_addr(0, 3, 0), '0, '0);  // Hit on unknown bytes
    // Partial enables merge, zero enables do nothing
    send(OP_WRITE, make_addr(0, 3, 1), 32'h1122_3344, 4'b0101);
    send(OP_READ, make_addr(0, 3, 1), '0, '0);
    send(OP_WRITE, make_addr(0, 3, 1), 32'hFFFF_FFFF, 4'b0000);
    send(OP_READ, make_addr(0, 3, 1), '0, '0);
    send(OP_WRITE, make_addr(2, 5, 0), 32'h5555_5555, 4'b0000);
    send(OP_READ, make_addr(2, 5, 0), '0, '0);  // No allocation
    // Invalidate with wrong then matching tag
    send(OP_INVAL, make_addr(1, 3, 0), '0, '0);
    send(OP_READ, make_addr(0, 3, 1), '0, '0);
    send(OP_INVAL, make_addr(0, 3, 3), '0, '0);
    send(OP_READ, make_addr(0, 3, 1), '0, '0);
    // Read straight after a write to the same word
    send(OP_WRITE, make_addr(3, 7, 3), 32'h0BAD_F00D, 4'hF);
    send(OP_READ, make_addr(3, 7, 3), '0, '0);
    idle();

    // Random mix every cycle, small tag pool for hits and aliasing
    for (int n = 0; n < `CACHE_TB_NUM_REQS; n++) begin
      kind  = int'($unsigned($random(seed)) % 8);
      addr  = make_addr(int'($unsigned($random(seed)) % `CACHE_TB_TAG_POOL),
                        int'($unsigned($random(seed)) % ENTRIES),
                        int'($unsigned($random(seed)) % BLOCK_WORDS));
      wdata = $random(seed);
      be    = BE_WIDTH'($random(seed));
      if (kind < 4) send(OP_READ, addr, '0, '0);
      else if (kind < 6) send(OP_WRITE, addr, wdata, be);
      else if (kind == 6) send(OP_INVAL, addr, '0, '0);
      else send(cache_op_e'(2'b11), addr, wdata, be);  // Unused opcode
    end
    idle();
    repeat (LATENCY + 2) @(posedge clk);

    if (exp_q.size() == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      abort_run($sformatf("%0d read responses never arrived", exp_q.size()));
    end
  end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the cache testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module cache_tb \
  -f tb.f \
  -o cache_sim

# The log decides the result
./obj_dir/cache_sim | tee "$LOG"

if grep -q "Simulation passed" "$LOG"; then
  echo "Result: PASS"
  exit 0
else
  echo "Result: FAIL"
  exit 1
fi

// ==== source/cache_pkg.sv ====
/* SI read cache package
   Address and word sizes, field limits, opcodes and the request, command and response structs */
package cache_pkg;

  localparam int ADDR_WIDTH = 32;       // Byte address
  localparam int WORD_WIDTH = 32;       // Data word
  localparam int BE_WIDTH   = WORD_WIDTH / 8; // One enable per byte

  // Upper bounds for fields carried in a command
  localparam int MAX_INDEX_WIDTH  = 8;  // Up to 256 lines
  localparam int MAX_OFFSET_WIDTH = 4;  // Up to 16 words per line

  // Requester opcodes, 2'b11 is unused
  typedef enum logic [1:0] {
    OP_READ  = 2'b00,
    OP_WRITE = 2'b01,
    OP_INVAL = 2'b10
  } cache_op_e;

  // Request as sent by the requester
  typedef struct packed {
    cache_op_e             op;
    logic [ADDR_WIDTH-1:0] addr;  // Byte address
    logic [WORD_WIDTH-1:0] wdata;
    logic [BE_WIDTH-1:0]   be;    // Byte enables for writes
  } cache_req_t;

  // Decoded command, address already split
  typedef struct packed {
    cache_op_e                   op;
    logic [ADDR_WIDTH-1:0]       tag;      // Zero extended
    logic [MAX_INDEX_WIDTH-1:0]  index;    // Zero extended
    logic [MAX_OFFSET_WIDTH-1:0] word_off; // Word within the line
    logic [WORD_WIDTH-1:0]       wdata;
    logic [BE_WIDTH-1:0]         be;
  } cache_cmd_t;

  // Read response
  typedef struct packed {
    logic                  hit;
    logic [WORD_WIDTH-1:0] data;  // Meaningless on a miss
  } cache_rsp_t;

endpackage

// ==== source/cache_req_decode.sv ====
/* Request decode stage
   Registers a request, splits its address and drops requests with no effect */
`timescale 1ns/100ps

module cache_req_decode import cache_pkg::*; #(
  parameter int ENTRIES     = 16,
  parameter int BLOCK_WORDS = 4
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       req_valid,
  input  cache_req_t req,
  output logic       cmd_valid,
  output cache_cmd_t cmd
);

  // Address split from the LSB up: byte, word, index, tag
  localparam int BYTE_OFF_W = $clog2(BE_WIDTH);
  localparam int OFF_W      = $clog2(BLOCK_WORDS);
  localparam int IDX_W      = $clog2(ENTRIES);
  localparam int IDX_LSB    = BYTE_OFF_W + OFF_W;
  localparam int TAG_LSB    = IDX_LSB + IDX_W;

  logic                  legal;     // Request changes or reads the array
  logic [ADDR_WIDTH-1:0] addr_off;  // Fields right aligned, full width
  logic [ADDR_WIDTH-1:0] addr_idx;
  logic [ADDR_WIDTH-1:0] addr_tag;

  // Masking with shifts keeps every slice nonzero for single word lines
  assign addr_off = (req.addr >> BYTE_OFF_W) & ADDR_WIDTH'(BLOCK_WORDS - 1);
  assign addr_idx = (req.addr >> IDX_LSB) & ADDR_WIDTH'(ENTRIES - 1);
  assign addr_tag = req.addr >> TAG_LSB;

  always_comb begin
    case (req.op)
      OP_READ:  legal = 1'b1;
      OP_INVAL: legal = 1'b1;
      OP_WRITE: legal = |req.be;  // No enabled bytes, nothing to do
      default:  legal = 1'b0;     // Unused encoding
    endcase
  end

  // Strobe into execute, one cycle after the request
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cmd_valid <= 1'b0;
    end else begin
      cmd_valid <= req_valid && legal;
    end
  end

  // Command payload, loaded on every strobe
  always_ff @(posedge clk) begin
    if (req_valid) begin
      cmd.op       <= req.op;
      cmd.tag      <= addr_tag;
      cmd.index    <= MAX_INDEX_WIDTH'(addr_idx);
      cmd.word_off <= MAX_OFFSET_WIDTH'(addr_off);
      cmd.wdata    <= req.wdata;
      cmd.be       <= req.be;
    end
  end

endmodule

// ==== source/cache_si.sv ====
/* Execute stage of the SI cache
   Line directory and data array; applies writes and invalidates, reads a line with its hit flag */
`timescale 1ns/100ps

module cache_si import cache_pkg::*; #(
  parameter int ENTRIES     = 16,
  parameter int BLOCK_WORDS = 4
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  cmd_valid,
  input  cache_cmd_t                            cmd,
  output logic                                  rd_valid,
  output logic                                  rd_hit,
  output logic [BLOCK_WORDS-1:0][WORD_WIDTH-1:0] rd_line,
  output logic [MAX_OFFSET_WIDTH-1:0]           rd_word_off
);

  localparam int BYTE_OFF_W = $clog2(BE_WIDTH);
  localparam int OFF_W      = $clog2(BLOCK_WORDS);
  localparam int IDX_W      = $clog2(ENTRIES);
  localparam int TAG_W      = ADDR_WIDTH - BYTE_OFF_W - OFF_W - IDX_W;

  // Only two states, no ownership
  typedef enum logic {
    st_invalid = 1'b0,
    st_shared  = 1'b1
  } line_state_e;

  typedef struct packed {
    line_state_e      state;
    logic [TAG_W-1:0] tag;
  } dir_entry_t;

  dir_entry_t                             dir_q  [ENTRIES];  // Per line state and tag
  logic [BLOCK_WORDS-1:0][WORD_WIDTH-1:0] data_q [ENTRIES];  // Line payload

  logic [IDX_W-1:0] idx;
  logic [TAG_W-1:0] tag;
  logic             tag_match;  // Line Shared with the same tag
  logic             do_write;
  logic             do_inval;
  logic             do_read;

  assign idx       = cmd.index[IDX_W-1:0];  // Upper bits are zero
  assign tag       = cmd.tag[TAG_W-1:0];
  assign tag_match = (dir_q[idx].state == st_shared) && (dir_q[idx].tag == tag);

  // Decode already removed illegal ops
  assign do_write = cmd_valid && (cmd.op == OP_WRITE);
  assign do_inval = cmd_valid && (cmd.op == OP_INVAL);
  assign do_read  = cmd_valid && (cmd.op == OP_READ);

  // Directory
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < ENTRIES; i++) begin
        dir_q[i].state <= st_invalid;  // Cold cache
        dir_q[i].tag   <= '0;
      end
    end else if (do_write) begin
      // Write allocate without refill, other words keep old contents
      dir_q[idx].state <= st_shared;
      dir_q[idx].tag   <= tag;
    end else if (do_inval && tag_match) begin
      dir_q[idx].state <= st_invalid;  // Tag miss leaves the line alone
    end
  end

  // Data array, byte granular write into one word lane
  always_ff @(posedge clk) begin
    if (do_write) begin
      for (int w = 0; w < BLOCK_WORDS; w++) begin
        if (cmd.word_off == MAX_OFFSET_WIDTH'(w)) begin
          for (int b = 0; b < BE_WIDTH; b++) begin
            if (cmd.be[b]) begin
              data_q[idx][w][b*8 +: 8] <= cmd.wdata[b*8 +: 8];
            end
          end
        end
      end
    end
  end

  // Read strobe into result stage
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= do_read;
    end
  end

  // Read data sees array contents from before this edge
  always_ff @(posedge clk) begin
    if (do_read) begin
      rd_line     <= data_q[idx];
      rd_hit      <= tag_match;
      rd_word_off <= cmd.word_off;
    end
  end

endmodule

// ==== source/cache_top.sv ====
/* SI read cache top level
   Chains decode, execute and result stages, two cycles request to response */
`timescale 1ns/100ps

module cache_top import cache_pkg::*; #(
  parameter int ENTRIES     = 16,  // Lines, power of two
  parameter int BLOCK_WORDS = 4    // Words per line, power of two
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       req_valid,
  input  cache_req_t req,
  output logic       rsp_valid,
  output cache_rsp_t rsp
);

  // Decode to execute
  logic       cmd_valid;
  cache_cmd_t cmd;

  // Execute to result
  logic                                   rd_valid;
  logic                                   rd_hit;
  logic [BLOCK_WORDS-1:0][WORD_WIDTH-1:0] rd_line;
  logic [MAX_OFFSET_WIDTH-1:0]            rd_word_off;

  cache_req_decode #(
    .ENTRIES     (ENTRIES),
    .BLOCK_WORDS (BLOCK_WORDS)
  ) decode_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req       (req),
    .cmd_valid (cmd_valid),
    .cmd       (cmd)
  );

  cache_si #(
    .ENTRIES     (ENTRIES),
    .BLOCK_WORDS (BLOCK_WORDS)
  ) array_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_valid   (cmd_valid),
    .cmd         (cmd),
    .rd_valid    (rd_valid),
    .rd_hit      (rd_hit),
    .rd_line     (rd_line),
    .rd_word_off (rd_word_off)
  );

  cache_word_select #(
    .BLOCK_WORDS (BLOCK_WORDS)
  ) select_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .rd_valid    (rd_valid),
    .rd_hit      (rd_hit),
    .rd_line     (rd_line),
    .rd_word_off (rd_word_off),
    .rsp_valid   (rsp_valid),
    .rsp         (rsp)
  );

endmodule

// ==== source/cache_word_select.sv ====
/* Result stage, picks the addressed word from the read line
   and registers it with the hit flag as the response */
`timescale 1ns/100ps

module cache_word_select import cache_pkg::*; #(
  parameter int BLOCK_WORDS = 4
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  rd_valid,
  input  logic                                  rd_hit,
  input  logic [BLOCK_WORDS-1:0][WORD_WIDTH-1:0] rd_line,
  input  logic [MAX_OFFSET_WIDTH-1:0]           rd_word_off,
  output logic                                  rsp_valid,
  output cache_rsp_t                            rsp
);

  logic [WORD_WIDTH-1:0] sel_word;  // Addressed word of the line

  // Compare based mux, safe for single word lines
  always_comb begin
    sel_word = rd_line[0];
    for (int w = 1; w < BLOCK_WORDS; w++) begin
      if (rd_word_off == MAX_OFFSET_WIDTH'(w)) begin
        sel_word = rd_line[w];
      end
    end
  end

  // One pulse per read
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= rd_valid;
    end
  end

  // Response payload, data is stale on a miss
  always_ff @(posedge clk) begin
    if (rd_valid) begin
      rsp.hit  <= rd_hit;
      rsp.data <= sel_word;
    end
  end

endmodule

// ==== tb.f ====
+incdir+include
source/cache_pkg.sv
source/cache_req_decode.sv
source/cache_si.sv
source/cache_word_select.sv
source/cache_top.sv
dv/cache_tb.sv
